// ==== logic/core_pkg.sv ====
/*
  core support package
  shared widths, bridge addresses and audio constants for the host-side logic
*/
`default_nettype none

package core_pkg;

  ////////////////////////////////////////
  // bridge bus
  localparam int BRIDGE_W = 32;

  ////////////////////////////////////////
  // program rom, word addressed, byte written
  // default depth, the top level may override it
  localparam int ROM_ADDR_W      = 14;
  localparam int ROM_WORD_W      = 16;
  localparam int ROM_BYTE_ADDR_W = ROM_ADDR_W + 1;

  // upper address bits of the program write window
  localparam logic [BRIDGE_W-1:0] ROM_WINDOW_BASE = 32'h1000_0000;

  // host readback map
  localparam logic [BRIDGE_W-1:0] RB_PGM_ADDR   = 32'h0000_0000;
  localparam logic [BRIDGE_W-1:0] RB_PGM_DATA   = 32'h0000_0004;
  localparam logic [BRIDGE_W-1:0] RB_BYTE_COUNT = 32'h0000_0008;

  ////////////////////////////////////////
  // audio
  // 74.25 mhz * 245760 / 742500 = 24.576 mhz toggle rate, so 12.288 mhz mclk
  localparam int MCLK_STEP        = 245760;
  localparam int MCLK_MODULUS     = 742500;
  // mclk toggles per bit clock period, sclk = mclk / 4
  localparam int SCLK_DIV_TOGGLES = 8;
  localparam int I2S_SLOT_W       = 32;
  localparam int SAMPLE_W         = 16;
  // one buzzer at full level, top two bits clear for headroom
  localparam logic [I2S_SLOT_W-1:0] BUZZER_LEVEL = 32'h3FFF_FFFF;

endpackage

`default_nettype wire

// ==== logic/rom_loader.sv ====
/*
  program rom loader
  catches 32-bit bridge writes in the program window and replays them
  as four byte writes, most significant byte first
*/
`default_nettype none

module rom_loader
  import core_pkg::*;
#(
  parameter int ROM_ADDR_W = core_pkg::ROM_ADDR_W
) (
  input  wire                clk_74a,
  input  wire                rst_n,
  input  wire [BRIDGE_W-1:0] bridge_addr,
  input  wire                bridge_wr,
  input  wire [BRIDGE_W-1:0] bridge_wr_data,
  output logic               rom_wr_en,
  output logic [ROM_ADDR_W:0] rom_wr_addr,
  output logic [7:0]         rom_wr_byte
);

  localparam int BYTE_AW = ROM_ADDR_W + 1;

  logic                win_wr;
  logic                busy;
  logic [1:0]          byte_cnt;
  logic [BRIDGE_W-1:0] word_q;
  logic [BYTE_AW-1:0]  addr_q;

  // window hit, upper bits only
  assign win_wr = bridge_wr &&
                  (bridge_addr[BRIDGE_W-1:BYTE_AW] == ROM_WINDOW_BASE[BRIDGE_W-1:BYTE_AW]);

  ////////////////////////////////////////
  // busy window, four cycles per accepted write
  always_ff @(posedge clk_74a)
  begin
    if (!rst_n)
    begin
      busy     <= 1'b0;
      byte_cnt <= 2'd0;
    end
    else if (busy)
    begin
      byte_cnt <= byte_cnt + 2'd1;
      // last byte going out now
      if (byte_cnt == 2'd3)
        busy <= 1'b0;
    end
    else if (win_wr)
    begin
      busy     <= 1'b1;
      byte_cnt <= 2'd0;
    end
  end

  // word and offset latch, then walk msb first
  // writes landing while busy are dropped
  always_ff @(posedge clk_74a)
  begin
    if (busy)
    begin
      word_q <= {word_q[BRIDGE_W-9:0], 8'h00};
      addr_q <= addr_q + 1'b1;
    end
    else if (win_wr)
    begin
      word_q <= bridge_wr_data;
      addr_q <= bridge_addr[BYTE_AW-1:0];
    end
  end

  assign rom_wr_en   = busy;
  assign rom_wr_addr = addr_q;
  assign rom_wr_byte = word_q[BRIDGE_W-1 -: 8];

endmodule

`default_nettype wire

// ==== logic/program_rom.sv ====
/*
  program rom
  byte-written from the loader, word-read by the cpu fetch port
  with one cycle of read latency
*/
`default_nettype none

module program_rom
  import core_pkg::*;
#(
  parameter int ROM_ADDR_W = core_pkg::ROM_ADDR_W
) (
  input  wire                  clk_74a,
  input  wire                  rom_wr_en,
  input  wire [ROM_ADDR_W:0]   rom_wr_addr,
  input  wire [7:0]            rom_wr_byte,
  input  wire [ROM_ADDR_W-1:0] pgm_addr,
  output logic [ROM_WORD_W-1:0] pgm_data
);

  // two byte lanes per word
  logic [ROM_WORD_W/8-1:0][7:0] mem [2**ROM_ADDR_W];

  // offset bit 0 picks the lane, 0 = low byte
  always_ff @(posedge clk_74a)
  begin
    if (rom_wr_en)
      mem[rom_wr_addr[ROM_ADDR_W:1]][rom_wr_addr[0]] <= rom_wr_byte;
  end

  // registered fetch
  // same-word write in the same cycle returns the old word
  always_ff @(posedge clk_74a)
  begin
    pgm_data <= mem[pgm_addr];
  end

endmodule

`default_nettype wire

// ==== logic/bridge_readback.sv ====
/*
  bridge readback
  host view of the fetch port and the loaded-byte counter,
  registered one cycle after bridge_rd
*/
`default_nettype none

module bridge_readback
  import core_pkg::*;
#(
  parameter int ROM_ADDR_W = core_pkg::ROM_ADDR_W
) (
  input  wire                  clk_74a,
  input  wire                  rst_n,
  input  wire [BRIDGE_W-1:0]   bridge_addr,
  input  wire                  bridge_rd,
  input  wire [ROM_ADDR_W-1:0] pgm_addr,
  input  wire [ROM_WORD_W-1:0] pgm_data,
  input  wire                  rom_wr_en,
  output logic [BRIDGE_W-1:0]  bridge_rd_data
);

  logic [BRIDGE_W-1:0] byte_count;
  logic [BRIDGE_W-1:0] rd_sel;

  // one count per rom byte write since reset
  always_ff @(posedge clk_74a)
  begin
    if (!rst_n)
      byte_count <= '0;
    else if (rom_wr_en)
      byte_count <= byte_count + 1'b1;
  end

  ////////////////////////////////////////
  // address decode
  always_comb
  begin
    case (bridge_addr)
      RB_PGM_ADDR:
        rd_sel = BRIDGE_W'(pgm_addr);
      RB_PGM_DATA:
        rd_sel = BRIDGE_W'(pgm_data);
      RB_BYTE_COUNT:
        rd_sel = byte_count;
      // unmapped reads as zero
      default:
        rd_sel = '0;
    endcase
  end

  // holds until the next read
  always_ff @(posedge clk_74a)
  begin
    if (!rst_n)
      bridge_rd_data <= '0;
    else if (bridge_rd)
      bridge_rd_data <= rd_sel;
  end

endmodule

`default_nettype wire

// ==== logic/i2s_clock_gen.sv ====
/*
  i2s clock generator
  fractional accumulator for the 12.288 mhz master clock, divided down
  to the bit clock with a one-cycle pulse on each falling bit-clock edge
*/
`default_nettype none

module i2s_clock_gen
  import core_pkg::*;
(
  input  wire  clk_74a,
  input  wire  rst_n,
  output logic audio_mclk,
  output logic audio_sclk,
  output logic sclk_fall
);

  localparam int ACC_W    = $clog2(MCLK_MODULUS + MCLK_STEP);
  localparam int HALF_TOG = SCLK_DIV_TOGGLES / 2;
  localparam int TOG_W    = $clog2(HALF_TOG);

  logic [ACC_W-1:0] accum;
  logic [ACC_W-1:0] acc_sum;
  logic             mclk_tog;
  logic [TOG_W-1:0] tog_cnt;
  logic             sclk_tog;

  // mclk edge whenever the sum crosses the modulus
  assign acc_sum  = accum + ACC_W'(MCLK_STEP);
  assign mclk_tog = (acc_sum >= ACC_W'(MCLK_MODULUS));
  // sclk edge on every HALF_TOG-th mclk edge
  assign sclk_tog = mclk_tog && (tog_cnt == TOG_W'(HALF_TOG - 1));

  ////////////////////////////////////////
  always_ff @(posedge clk_74a)
  begin
    if (!rst_n)
    begin
      accum      <= '0;
      audio_mclk <= 1'b0;
      tog_cnt    <= '0;
      audio_sclk <= 1'b0;
      sclk_fall  <= 1'b0;
    end
    else
    begin
      accum <= mclk_tog ? acc_sum - ACC_W'(MCLK_MODULUS) : acc_sum;
      // high while sclk sits in its first low cycle
      sclk_fall <= sclk_tog && audio_sclk;
      if (mclk_tog)
      begin
        audio_mclk <= ~audio_mclk;
        tog_cnt    <= sclk_tog ? '0 : tog_cnt + 1'b1;
      end
      if (sclk_tog)
        audio_sclk <= ~audio_sclk;
    end
  end

endmodule

`default_nettype wire

// ==== logic/i2s_serializer.sv ====
/*
  i2s serializer
  mixes the two buzzer levels into one sample and shifts it out
  msb first, one slot after each word-select rise
*/
`default_nettype none

module i2s_serializer
  import core_pkg::*;
(
  input  wire  clk_74a,
  input  wire  rst_n,
  input  wire  sclk_fall,
  input  wire  buzzer1,
  input  wire  buzzer2,
  output logic audio_lrck,
  output logic audio_dac
);

  localparam int SLOT_CNT_W = $clog2(I2S_SLOT_W);
  // active part of one buzzer level
  localparam logic [SAMPLE_W-1:0] LEVEL_ACT = BUZZER_LEVEL[I2S_SLOT_W-1 -: SAMPLE_W];

  logic [SAMPLE_W-1:0]   mix_act;
  logic [I2S_SLOT_W-1:0] sample;
  logic [SLOT_CNT_W-1:0] slot_cnt;
  logic [I2S_SLOT_W-1:0] shifter;

  ////////////////////////////////////////
  // mixer
  // summed over the active bits only, both on gives 7ffe
  assign mix_act = (buzzer1 ? LEVEL_ACT : '0) + (buzzer2 ? LEVEL_ACT : '0);
  // dummy slots padded with zero
  assign sample  = {mix_act, {(I2S_SLOT_W - SAMPLE_W){1'b0}}};

  ////////////////////////////////////////
  // slot engine, advances on falling sclk
  always_ff @(posedge clk_74a)
  begin
    if (!rst_n)
    begin
      slot_cnt   <= '0;
      audio_lrck <= 1'b0;
      audio_dac  <= 1'b0;
      // clean shifter keeps the first frame silent
      shifter    <= '0;
    end
    else if (sclk_fall)
    begin
      audio_dac <= shifter[I2S_SLOT_W-1];
      slot_cnt  <= slot_cnt + 1'b1;
      if (slot_cnt == SLOT_CNT_W'(I2S_SLOT_W - 1))
      begin
        // channel switch
        audio_lrck <= ~audio_lrck;
        // new word only ahead of the lrck-high half
        if (!audio_lrck)
          shifter <= sample;
      end
      else if (slot_cnt < SLOT_CNT_W'(SAMPLE_W))
      begin
        // 16 active bits, then zeros reach the msb
        shifter <= {shifter[I2S_SLOT_W-2:0], 1'b0};
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/arduboy_core.sv ====
/*
  arduboy host-side core
  program loader, rom fetch port, bridge readback and i2s buzzer audio,
  all in the clk_74a domain
*/
`default_nettype none

module arduboy_core
  import core_pkg::*;
#(
  parameter int ROM_ADDR_W = core_pkg::ROM_ADDR_W
) (
  input  wire                  clk_74a,
  input  wire                  rst_n,
  // bridge
  input  wire [BRIDGE_W-1:0]   bridge_addr,
  input  wire                  bridge_wr,
  input  wire [BRIDGE_W-1:0]   bridge_wr_data,
  input  wire                  bridge_rd,
  output logic [BRIDGE_W-1:0]  bridge_rd_data,
  // cpu fetch port
  input  wire [ROM_ADDR_W-1:0] pgm_addr,
  output logic [ROM_WORD_W-1:0] pgm_data,
  // buzzers and i2s
  input  wire                  buzzer1,
  input  wire                  buzzer2,
  output logic                 audio_mclk,
  output logic                 audio_sclk,
  output logic                 audio_lrck,
  output logic                 audio_dac
);

  logic                rom_wr_en;
  logic [ROM_ADDR_W:0] rom_wr_addr;
  logic [7:0]          rom_wr_byte;
  logic                sclk_fall;

  ////////////////////////////////////////
  // program load and fetch
  rom_loader #(
    .ROM_ADDR_W (ROM_ADDR_W)
  ) u_rom_loader (
    .clk_74a        (clk_74a),
    .rst_n          (rst_n),
    .bridge_addr    (bridge_addr),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .rom_wr_en      (rom_wr_en),
    .rom_wr_addr    (rom_wr_addr),
    .rom_wr_byte    (rom_wr_byte)
  );

  program_rom #(
    .ROM_ADDR_W (ROM_ADDR_W)
  ) u_program_rom (
    .clk_74a     (clk_74a),
    .rom_wr_en   (rom_wr_en),
    .rom_wr_addr (rom_wr_addr),
    .rom_wr_byte (rom_wr_byte),
    .pgm_addr    (pgm_addr),
    .pgm_data    (pgm_data)
  );

  // host readback
  bridge_readback #(
    .ROM_ADDR_W (ROM_ADDR_W)
  ) u_bridge_readback (
    .clk_74a        (clk_74a),
    .rst_n          (rst_n),
    .bridge_addr    (bridge_addr),
    .bridge_rd      (bridge_rd),
    .pgm_addr       (pgm_addr),
    .pgm_data       (pgm_data),
    .rom_wr_en      (rom_wr_en),
    .bridge_rd_data (bridge_rd_data)
  );

  ////////////////////////////////////////
  // audio
  i2s_clock_gen u_i2s_clock_gen (
    .clk_74a    (clk_74a),
    .rst_n      (rst_n),
    .audio_mclk (audio_mclk),
    .audio_sclk (audio_sclk),
    .sclk_fall  (sclk_fall)
  );

  i2s_serializer u_i2s_serializer (
    .clk_74a    (clk_74a),
    .rst_n      (rst_n),
    .sclk_fall  (sclk_fall),
    .buzzer1    (buzzer1),
    .buzzer2    (buzzer2),
    .audio_lrck (audio_lrck),
    .audio_dac  (audio_dac)
  );

endmodule

`default_nettype wire

// ==== dv/arduboy_core_chk.sv ====
/*
  arduboy_core protocol checker
  host write spacing, loader burst length and bit-clock pulse width
*/
`default_nettype none

module arduboy_core_chk (
  input wire clk_74a,
  input wire rst_n,
  input wire win_wr,
  input wire busy,
  input wire rom_wr_en,
  input wire sclk_fall
);
  timeunit 1ns;
  timeprecision 100ps;

  // host rule, no window write during a byte replay
  no_write_while_busy: assert property (@(posedge clk_74a) disable iff (!rst_n)
    busy |-> !win_wr)
    else $error("window write arrived while the loader was busy");

  // one burst is exactly four byte writes
  wr_burst_len: assert property (@(posedge clk_74a) disable iff (!rst_n)
    $rose(rom_wr_en) |=> rom_wr_en ##1 rom_wr_en ##1 rom_wr_en ##1 !rom_wr_en)
    else $error("rom_wr_en burst was not four cycles long");

  // falling-edge strobe
  sclk_fall_width: assert property (@(posedge clk_74a) disable iff (!rst_n)
    sclk_fall |=> !sclk_fall)
    else $error("sclk_fall stayed high for more than one cycle");

endmodule

bind rom_loader arduboy_core_chk u_loader_chk (
  .clk_74a   (clk_74a),
  .rst_n     (rst_n),
  .win_wr    (win_wr),
  .busy      (busy),
  .rom_wr_en (rom_wr_en),
  .sclk_fall (1'b0)
);

bind i2s_serializer arduboy_core_chk u_i2s_chk (
  .clk_74a   (clk_74a),
  .rst_n     (rst_n),
  .win_wr    (1'b0),
  .busy      (1'b0),
  .rom_wr_en (1'b0),
  .sclk_fall (sclk_fall)
);

`default_nettype wire

// ==== dv/arduboy_core_tb.sv ====
/*
  arduboy_core testbench
  replays the operations of dv/core_tests.txt against the loader,
  fetch port, readback registers and i2s output
*/
`default_nettype none

module arduboy_core_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int     ROM_AW       = 14;
  localparam longint MCLK_NUM     = 245760;
  localparam longint MCLK_DEN     = 742500;
  // three i2s frames of about 1550 cycles each, with margin
  localparam int     AUDIO_BUDGET = 6000;

  logic              clk_74a;
  logic              rst_n;
  logic [31:0]       bridge_addr;
  logic              bridge_wr;
  logic [31:0]       bridge_wr_data;
  logic              bridge_rd;
  logic [31:0]       bridge_rd_data;
  logic [ROM_AW-1:0] pgm_addr;
  logic [15:0]       pgm_data;
  logic              buzzer1;
  logic              buzzer2;
  logic              audio_mclk;
  logic              audio_sclk;
  logic              audio_lrck;
  logic              audio_dac;

  // parsed operations
  byte         op_q    [$];
  logic [31:0] arg_a_q [$];
  logic [31:0] arg_b_q [$];
  logic [31:0] arg_c_q [$];

  int   errors;
  int   checks;
  int   cycle_cnt;
  int   cycle_limit;
  logic limit_ready;
  logic sclk_prev;

  arduboy_core #(
    .ROM_ADDR_W (ROM_AW)
  ) uut (
    .clk_74a        (clk_74a),
    .rst_n          (rst_n),
    .bridge_addr    (bridge_addr),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .bridge_rd      (bridge_rd),
    .bridge_rd_data (bridge_rd_data),
    .pgm_addr       (pgm_addr),
    .pgm_data       (pgm_data),
    .buzzer1        (buzzer1),
    .buzzer2        (buzzer2),
    .audio_mclk     (audio_mclk),
    .audio_sclk     (audio_sclk),
    .audio_lrck     (audio_lrck),
    .audio_dac      (audio_dac)
  );

  // 4 ns clock
  initial
  begin
    clk_74a = 1'b0;
    forever #2 clk_74a = ~clk_74a;
  end

  // watchdog, limit summed from the operation budgets
  initial
  begin
    wait (limit_ready);
    while (cycle_cnt < cycle_limit)
    begin
      @(posedge clk_74a);
      cycle_cnt++;
    end
    $display("timeout: run exceeded %0d cycles", cycle_limit);
    $display("RESULT: FAIL");
    $finish;
  end

  ////////////////////////////////////////
  // helpers

  // inputs change 1 ns after the rising edge
  task automatic step();
    @(posedge clk_74a);
    #1;
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    assert (actual === expected)
    else
    begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s expected %h, got %h",
               $time, name, expected, actual);
    end
  endtask

  function automatic int op_budget(input byte op, input logic [31:0] a);
    case (op)
      "W": return 8;
      "F": return 4;
      "R": return 4;
      "A": return AUDIO_BUDGET;
      "M": return int'(a) + 8;
      default: return 4;
    endcase
  endfunction

  task automatic load_tests();
    int          fd;
    int          rc;
    string       line;
    byte         op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    fd = $fopen("dv/core_tests.txt", "r");
    if (fd == 0)
      return;
    while (!$feof(fd))
    begin
      line = "";
      rc = $fgets(line, fd);
      if (rc > 1)
      begin
        op = line.getc(0);
        // comment and blank lines carry no opcode letter
        if (op == "W" || op == "F" || op == "R" || op == "A" || op == "M")
        begin
          a = '0;
          b = '0;
          c = '0;
          rc = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, c);
          op_q.push_back(op);
          arg_a_q.push_back(a);
          arg_b_q.push_back(b);
          arg_c_q.push_back(c);
          cycle_limit += op_budget(op, a);
        end
      end
    end
    $fclose(fd);
  endtask

  ////////////////////////////////////////
  // bridge and fetch port

  task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
    step();
    bridge_addr    = addr;
    bridge_wr_data = data;
    bridge_wr      = 1'b1;
    step();
    bridge_wr = 1'b0;
    // four byte writes follow, host stays quiet
    repeat (4) step();
  endtask

  task automatic fetch(input logic [ROM_AW-1:0] addr, input logic [15:0] expected);
    step();
    pgm_addr = addr;
    step();
    check_value("pgm_data", 32'(expected), 32'(pgm_data));
  endtask

  task automatic readback(input logic [31:0] addr, input logic [31:0] expected);
    step();
    bridge_addr = addr;
    bridge_rd   = 1'b1;
    step();
    bridge_rd = 1'b0;
    check_value("bridge_rd_data", expected, bridge_rd_data);
  endtask

  ////////////////////////////////////////
  // audio

  // sclk only moves on rising clk edges, so sample at the falling one
  task automatic next_sclk_rise(output logic lr, output logic dat);
    logic seen;
    seen = 1'b0;
    while (!seen)
    begin
      @(negedge clk_74a);
      seen      = audio_sclk && !sclk_prev;
      sclk_prev = audio_sclk;
    end
    lr  = audio_lrck;
    dat = audio_dac;
  endtask

  // returns on the first bit of the lrck-high half, the skipped one
  task automatic wait_lrck_rise();
    logic lr;
    logic lr_last;
    logic dat;
    next_sclk_rise(lr_last, dat);
    next_sclk_rise(lr, dat);
    while (!(lr && !lr_last))
    begin
      lr_last = lr;
      next_sclk_rise(lr, dat);
    end
  endtask

  task automatic check_audio(input logic b1, input logic b2, input logic [15:0] expected);
    logic        lr;
    logic        dat;
    logic [15:0] word;
    int          low_bits;
    step();
    buzzer1   = b1;
    buzzer2   = b2;
    sclk_prev = audio_sclk;
    // first frame settles the new mix, second one is checked
    wait_lrck_rise();
    wait_lrck_rise();
    word = '0;
    repeat (16)
    begin
      next_sclk_rise(lr, dat);
      word = {word[14:0], dat};
    end
    check_value("audio_dac word", 32'(expected), 32'(word));
    // whole lrck-low half must be silent
    low_bits = 0;
    while (low_bits < 32)
    begin
      next_sclk_rise(lr, dat);
      if (!lr)
      begin
        check_value("audio_dac", 32'h0, 32'(dat));
        low_bits++;
      end
    end
  endtask

  task automatic count_mclk(input int cycles);
    int     toggles;
    logic   mclk_last;
    longint expected;
    longint diff;
    toggles = 0;
    step();
    mclk_last = audio_mclk;
    repeat (cycles)
    begin
      step();
      if (audio_mclk != mclk_last)
        toggles++;
      mclk_last = audio_mclk;
    end
    expected = longint'(cycles) * MCLK_NUM / MCLK_DEN;
    diff     = longint'(toggles) - expected;
    checks++;
    assert (diff >= -1 && diff <= 1)
    else
    begin
      errors++;
      $display("CHECK FAILED at %0t ns: audio_mclk toggles expected %0d, got %0d",
               $time, expected, toggles);
    end
  endtask

  task automatic run_op(input byte op, input logic [31:0] a, input logic [31:0] b,
                        input logic [31:0] c);
    case (op)
      "W": bridge_write(a, b);
      "F": fetch(a[ROM_AW-1:0], b[15:0]);
      "R": readback(a, b);
      "A": check_audio(a[0], b[0], c[15:0]);
      "M": count_mclk(int'(a));
      default:
      begin
        errors++;
        $display("unknown opcode in test file");
      end
    endcase
  endtask

  ////////////////////////////////////////
  // main sequence
  initial
  begin
    rst_n          = 1'b0;
    bridge_addr    = '0;
    bridge_wr      = 1'b0;
    bridge_wr_data = '0;
    bridge_rd      = 1'b0;
    pgm_addr       = '0;
    buzzer1        = 1'b0;
    buzzer2        = 1'b0;
    errors         = 0;
    checks         = 0;
    cycle_cnt      = 0;
    sclk_prev      = 1'b0;
    // reset plus slack
    cycle_limit    = 100;
    limit_ready    = 1'b0;
    load_tests();
    limit_ready = 1'b1;
    if (op_q.size() == 0)
    begin
      errors++;
      $display("no operations could be read from dv/core_tests.txt");
    end
    repeat (16) step();
    // reset state of the audio outputs
    check_value("audio_mclk", 32'h0, 32'(audio_mclk));
    check_value("audio_sclk", 32'h0, 32'(audio_sclk));
    check_value("audio_lrck", 32'h0, 32'(audio_lrck));
    check_value("audio_dac", 32'h0, 32'(audio_dac));
    rst_n = 1'b1;
    step();
    for (int i = 0; i < op_q.size(); i++)
      run_op(op_q[i], arg_a_q[i], arg_b_q[i], arg_c_q[i]);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
logic/core_pkg.sv
logic/rom_loader.sv
logic/program_rom.sv
logic/bridge_readback.sv
logic/i2s_clock_gen.sv
logic/i2s_serializer.sv
logic/arduboy_core.sv
dv/arduboy_core_chk.sv
dv/arduboy_core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the arduboy_core testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --timescale 1ns/100ps \
  -f project.f \
  --top-module arduboy_core_tb \
  -o arduboy_core_sim

./obj_dir/arduboy_core_sim | tee sim.log

# the testbench prints its verdict on a line of its own
if grep -qx "RESULT: PASS" sim.log
then
  exit 0
fi
exit 1

// ==== dv/core_tests.txt ====
# op arg_a arg_b arg_c, all fields hex
# W addr data | F pgm_addr exp_data | R addr exp_value | A buzzer1 buzzer2 exp_word | M cycles
R 00000008 00000000
W 10000000 12345678
W 10000004 A1B2C3D4
W 10000100 DEADBEEF
F 00000000 00003412
F 00000001 00007856
F 00000002 0000B2A1
F 00000003 0000D4C3
F 00000080 0000ADDE
F 00000081 0000EFBE
W 10008000 FFFFFFFF
W 20000000 FFFFFFFF
F 00000000 00003412
F 00000081 0000EFBE
R 00000008 0000000C
R 00000000 00000081
R 00000004 0000EFBE
R 00000010 00000000
A 00000000 00000000 00000000
A 00000001 00000000 00003FFF
A 00000000 00000001 00003FFF
A 00000001 00000001 00007FFE
M 00000BB8
